// ==== Makefile ====
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module tb_fetch -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/Vtb_fetch)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^=== PASS ===$$"

clean:
	rm -rf obj_dir

// ==== fetch_apb_master.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_apb_master
    import rvc_pkg::*;
(
    input  wire logic             clk_i,
    input  wire logic             rst_i,
    input  wire logic             word_ready_i,
    output logic                  word_valid_o,
    output fetch_word_t           word_o,
    output logic                  psel_o,
    output logic                  penable_o,
    output logic [XLEN-1:0]       paddr_o,
    input  wire logic [XLEN-1:0]  prdata_i,
    input  wire logic             pready_i,
    input  wire logic             pslverr_i
);

    apb_state_e      state_q, state_nxt;
    logic [XLEN-1:0] addr_q;    // address of the word being or next fetched
    logic            done;      // access completes this cycle

    assign done = (state_q == ACCESS) && pready_i;

    always_comb begin
        state_nxt = state_q;
        case (state_q)
            IDLE:    if (word_ready_i) state_nxt = SETUP;   // only with room reserved
            SETUP:   state_nxt = ACCESS;
            ACCESS:  if (pready_i) state_nxt = word_ready_i ? SETUP : IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            state_q <= IDLE;
            addr_q  <= RESET_PC;
        end else begin
            state_q <= state_nxt;
            if (done)
                addr_q <= addr_q + 32'd4;   // strictly sequential
        end
    end

    // ------------------------------------------------------------------
    // bus and word channel outputs
    // ------------------------------------------------------------------
    assign psel_o         = (state_q != IDLE);
    assign penable_o      = (state_q == ACCESS);
    assign paddr_o        = addr_q;
    assign word_valid_o   = done;
    assign word_o.data    = prdata_i;
    assign word_o.addr    = addr_q;
    assign word_o.bus_err = pslverr_i;

    a_setup_first: assert property (@(posedge clk_i) disable iff (!rst_i)
        penable_o |-> psel_o && $past(psel_o));
    a_addr_hold: assert property (@(posedge clk_i) disable iff (!rst_i)
        psel_o && !(penable_o && pready_i) |=> $stable(paddr_o));

endmodule

`default_nettype wire

// ==== fetch_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_top
    import rvc_pkg::*;
(
    input  wire logic             clk_i,
    input  wire logic             rst_i,
    // apb toward instruction memory
    output logic                  psel_o,
    output logic                  penable_o,
    output logic [XLEN-1:0]       paddr_o,
    input  wire logic [XLEN-1:0]  prdata_i,
    input  wire logic             pready_i,
    input  wire logic             pslverr_i,
    // instruction stream out
    output logic                  inst_valid_o,
    output fetch_instr_t          inst_o,
    input  wire logic             inst_ready_i
);

    logic        word_valid, word_ready;
    fetch_word_t word;
    raw_instr_t  raw_instr;

    fetch_apb_master fetch_apb_master_i (
        .clk_i, .rst_i,
        .word_ready_i (word_ready), .word_valid_o (word_valid), .word_o (word),
        .psel_o, .penable_o, .paddr_o, .prdata_i, .pready_i, .pslverr_i
    );

    instr_realigner instr_realigner_i (
        .clk_i, .rst_i,
        .word_valid_i (word_valid), .word_i (word), .word_ready_o (word_ready),
        .instr_valid_o (inst_valid_o), .instr_o (raw_instr), .instr_ready_i (inst_ready_i)
    );

    rvc_expander rvc_expander_i (.instr_i (raw_instr), .instr_o (inst_o));   // no latency

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+.
rvc_pkg.sv
rvc_expander.sv
instr_realigner.sv
fetch_apb_master.sv
fetch_top.sv
tb_fetch.sv

// ==== instr_realigner.sv ====
`timescale 1ns/100ps
`default_nettype none

module instr_realigner
    import rvc_pkg::*;
(
    input  wire logic         clk_i,
    input  wire logic         rst_i,
    input  wire logic         word_valid_i,
    input  wire fetch_word_t  word_i,
    output logic              word_ready_o,
    output logic              instr_valid_o,
    output raw_instr_t        instr_o,
    input  wire logic         instr_ready_i
);

    logic [BUF_HW*16-1:0] buf_q, buf_nxt;   // halfword 0 is the oldest
    logic [BUF_HW-1:0]    err_q, err_nxt;   // bus_err per halfword
    logic [1:0]           cnt_q, cnt_rem;
    logic [2:0]           cnt_nxt;
    logic [XLEN-1:0]      pc_q, pc_nxt;     // pc of halfword 0
    logic                 is32, have, out_free, load;
    logic [1:0]           take;             // halfwords consumed this cycle
    logic                 instr_valid_q;
    raw_instr_t           instr_q;

    // ------------------------------------------------------------------
    // length detect, consume, append
    // ------------------------------------------------------------------
    always_comb begin
        is32     = (quadrant_e'(buf_q[1:0]) == Q3);
        have     = is32 ? (cnt_q >= 2'd2) : (cnt_q >= 2'd1);
        out_free = !instr_valid_q || instr_ready_i;
        load     = out_free && have;
        take     = load ? (is32 ? 2'd2 : 2'd1) : 2'd0;
        cnt_rem  = cnt_q - take;
        buf_nxt  = buf_q >> (16 * take);            // drop consumed halfwords
        err_nxt  = err_q >> take;
        pc_nxt   = pc_q + {{(XLEN-3){1'b0}}, take, 1'b0};
        cnt_nxt  = {1'b0, cnt_rem};
        if (word_valid_i) begin
            cnt_nxt = cnt_rem + 3'd2;
            if (cnt_rem == 2'd0) begin              // empty, restart pc from word
                buf_nxt[31:0] = word_i.data;
                err_nxt[1:0]  = {2{word_i.bus_err}};
                pc_nxt        = word_i.addr;
            end else begin                          // one halfword left over
                buf_nxt[47:16] = word_i.data;
                err_nxt[2:1]   = {2{word_i.bus_err}};
            end
        end
    end

    // room for a whole word even after anything arriving now
    assign word_ready_o = (cnt_nxt <= 3'(BUF_HW - 2));

    // ------------------------------------------------------------------
    // state and output register
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            cnt_q         <= 2'd0;
            pc_q          <= RESET_PC;
            instr_valid_q <= 1'b0;
        end else begin
            cnt_q <= cnt_nxt[1:0];
            pc_q  <= pc_nxt;
            if (load)
                instr_valid_q <= 1'b1;
            else if (instr_ready_i)
                instr_valid_q <= 1'b0;              // taken, nothing new
        end
    end

    always_ff @(posedge clk_i) begin
        buf_q <= buf_nxt;
        err_q <= err_nxt;
        if (load) begin
            instr_q.pc         <= pc_q;
            instr_q.instr      <= is32 ? buf_q[31:0] : {16'h0000, buf_q[15:0]};
            instr_q.compressed <= !is32;
            instr_q.bus_err    <= is32 ? (err_q[0] | err_q[1]) : err_q[0];
        end
    end

    assign instr_valid_o = instr_valid_q;
    assign instr_o       = instr_q;

    // stalled output holds until the consumer takes it
    a_hold: assert property (@(posedge clk_i) disable iff (!rst_i)
        instr_valid_o && !instr_ready_i |=> instr_valid_o && $stable(instr_o));

endmodule

`default_nettype wire

// ==== rvc_expander.sv ====
`timescale 1ns/100ps
`default_nettype none

module rvc_expander
    import rvc_pkg::*;
(
    input  wire raw_instr_t   instr_i,
    output fetch_instr_t      instr_o
);

    // ------------------------------------------------------------------
    // field extraction from the compressed halfword
    // ------------------------------------------------------------------
    logic [15:0] c;
    quadrant_e   quad;
    logic [2:0]  f3;
    logic [4:0]  rd;            // also rs1 for ci/cr forms
    logic [4:0]  rs2;
    logic [4:0]  rdp;           // x8..x15, also rs2'
    logic [4:0]  rs1p;          // x8..x15
    logic [11:0] imm_ci;        // sign extended 6-bit immediate
    logic [11:0] imm_4spn;
    logic [11:0] imm_lw;        // c.lw / c.sw offset
    logic [11:0] imm_16sp;
    logic [11:0] imm_lwsp;
    logic [11:0] imm_swsp;
    logic [12:0] imm_b;         // branch offset, bit 0 zero
    logic [20:0] imm_j;         // jump offset, bit 0 zero
    logic [31:0] exp_instr;
    logic        ill_c;

    assign c    = instr_i.instr[15:0];
    assign quad = quadrant_e'(c[1:0]);
    assign f3   = c[15:13];
    assign rd   = c[11:7];
    assign rs2  = c[6:2];
    assign rdp  = {2'b01, c[4:2]};
    assign rs1p = {2'b01, c[9:7]};

    assign imm_ci   = {{7{c[12]}}, c[6:2]};
    assign imm_4spn = {2'b00, c[10:7], c[12:11], c[5], c[6], 2'b00};
    assign imm_lw   = {5'b00000, c[5], c[12:10], c[6], 2'b00};
    assign imm_16sp = {{3{c[12]}}, c[4:3], c[5], c[2], c[6], 4'b0000};
    assign imm_lwsp = {4'b0000, c[3:2], c[12], c[6:4], 2'b00};
    assign imm_swsp = {4'b0000, c[8:7], c[12:9], 2'b00};
    assign imm_b    = {{5{c[12]}}, c[6:5], c[2], c[11:10], c[4:3], 1'b0};
    assign imm_j    = {{10{c[12]}}, c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};

    // ------------------------------------------------------------------
    // expansion table
    // ------------------------------------------------------------------
    always_comb begin
        exp_instr = '0;
        ill_c     = 1'b0;
        case (quad)
            Q0: begin
                case (f3)
                    3'b000: begin                           // c.addi4spn
                        exp_instr = {imm_4spn, 5'd2, 3'b000, rdp, OP_IMM};
                        ill_c     = (c[12:5] == 8'h00);     // catches all-zero halfword too
                    end
                    3'b010: exp_instr = {imm_lw, rs1p, 3'b010, rdp, LOAD};   // c.lw
                    3'b110: begin                           // c.sw
                        exp_instr = {imm_lw[11:5], rdp, rs1p, 3'b010, imm_lw[4:0], STORE};
                    end
                    default: ill_c = 1'b1;                  // fp forms and reserved slot
                endcase
            end
            Q1: begin
                case (f3)
                    3'b000: exp_instr = {imm_ci, rd, 3'b000, rd, OP_IMM};       // c.addi / c.nop
                    3'b001, 3'b101: begin                   // c.jal links x1, c.j links x0
                        exp_instr = {imm_j[20], imm_j[10:1], imm_j[11], imm_j[19:12],
                                     4'b0000, ~f3[2], JAL};
                    end
                    3'b010: exp_instr = {imm_ci, 5'd0, 3'b000, rd, OP_IMM};     // c.li
                    3'b011: begin
                        ill_c = ({c[12], c[6:2]} == 6'b000000);  // zero imm reserved
                        if (rd == 5'd2)                           // c.addi16sp
                            exp_instr = {imm_16sp, 5'd2, 3'b000, 5'd2, OP_IMM};
                        else                                      // c.lui
                            exp_instr = {{15{c[12]}}, c[6:2], rd, LUI};
                    end
                    3'b100: begin
                        case (c[11:10])
                            2'b00: begin                    // c.srli
                                exp_instr = {7'b0000000, c[6:2], rs1p, 3'b101, rs1p, OP_IMM};
                                ill_c     = c[12];          // shamt[5] is rv64 only
                            end
                            2'b01: begin                    // c.srai
                                exp_instr = {7'b0100000, c[6:2], rs1p, 3'b101, rs1p, OP_IMM};
                                ill_c     = c[12];
                            end
                            2'b10: exp_instr = {imm_ci, rs1p, 3'b111, rs1p, OP_IMM};  // c.andi
                            default: begin
                                ill_c = c[12];              // subw / addw not on rv32
                                case (c[6:5])
                                    2'b00: exp_instr = {7'b0100000, rdp, rs1p, 3'b000, rs1p, OP};
                                    2'b01: exp_instr = {7'b0000000, rdp, rs1p, 3'b100, rs1p, OP};
                                    2'b10: exp_instr = {7'b0000000, rdp, rs1p, 3'b110, rs1p, OP};
                                    default: exp_instr = {7'b0000000, rdp, rs1p, 3'b111, rs1p, OP};
                                endcase
                            end
                        endcase
                    end
                    default: begin                          // c.beqz / c.bnez
                        exp_instr = {imm_b[12], imm_b[10:5], 5'd0, rs1p, 2'b00, f3[0],
                                     imm_b[4:1], imm_b[11], BRANCH};
                    end
                endcase
            end
            Q2: begin
                case (f3)
                    3'b000: begin                           // c.slli
                        exp_instr = {7'b0000000, c[6:2], rd, 3'b001, rd, OP_IMM};
                        ill_c     = c[12];
                    end
                    3'b010: begin                           // c.lwsp
                        exp_instr = {imm_lwsp, 5'd2, 3'b010, rd, LOAD};
                        ill_c     = (rd == 5'd0);
                    end
                    3'b100: begin
                        if (!c[12] && rs2 == 5'd0) begin    // c.jr
                            exp_instr = {12'h000, rd, 3'b000, 5'd0, JALR};
                            ill_c     = (rd == 5'd0);
                        end else if (!c[12]) begin          // c.mv
                            exp_instr = {7'b0000000, rs2, 5'd0, 3'b000, rd, OP};
                        end else if (rs2 == 5'd0) begin
                            exp_instr = {12'h000, rd, 3'b000, 5'd1, JALR};  // c.jalr
                            ill_c     = (rd == 5'd0);       // c.ebreak, no system opcode here
                        end else begin                      // c.add
                            exp_instr = {7'b0000000, rs2, rd, 3'b000, rd, OP};
                        end
                    end
                    3'b110: begin                           // c.swsp
                        exp_instr = {imm_swsp[11:5], rs2, 5'd2, 3'b010, imm_swsp[4:0], STORE};
                    end
                    default: ill_c = 1'b1;                  // fp stack forms
                endcase
            end
            default: ill_c = 1'b1;                          // q3 never marked compressed
        endcase
    end

    assign instr_o.pc         = instr_i.pc;
    assign instr_o.instr      = instr_i.compressed ? exp_instr : instr_i.instr;
    assign instr_o.compressed = instr_i.compressed;
    assign instr_o.illegal    = instr_i.compressed ? ill_c : (&instr_i.instr);  // all ones
    assign instr_o.bus_err    = instr_i.bus_err;

endmodule

`default_nettype wire

// ==== rvc_pkg.sv ====
`default_nettype none

package rvc_pkg;

    // ------------------------------------------------------------------
    // widths and constants
    // ------------------------------------------------------------------
    localparam int unsigned XLEN     = 32;              // data and address width
    localparam logic [31:0] RESET_PC = 32'h0000_0000;   // first fetch address
    localparam int unsigned BUF_HW   = 3;               // realigner depth in halfwords

    // base opcodes produced by the expander
    typedef enum logic [6:0] {
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011,
        LUI    = 7'b0110111,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111
    } opcode_e;

    // instr[1:0], Q3 marks a 32-bit instruction
    typedef enum logic [1:0] {
        Q0 = 2'b00,
        Q1 = 2'b01,
        Q2 = 2'b10,
        Q3 = 2'b11
    } quadrant_e;

    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        ACCESS
    } apb_state_e;

    // ------------------------------------------------------------------
    // payloads between the fetch blocks
    // ------------------------------------------------------------------
    typedef struct packed {
        logic [XLEN-1:0] data;      // prdata as read
        logic [XLEN-1:0] addr;      // word address
        logic            bus_err;   // pslverr of this transfer
    } fetch_word_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [31:0]     instr;       // upper half zero for compressed
        logic            compressed;
        logic            bus_err;
    } raw_instr_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [31:0]     instr;       // always the 32-bit base form
        logic            compressed;
        logic            illegal;
        logic            bus_err;
    } fetch_instr_t;

endpackage

`default_nettype wire

// ==== tb_vectors.svh ====
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// ----------------------------------------------------------------------
// instruction memory image and expected fetch stream
// ----------------------------------------------------------------------
localparam int          N_HW     = 28;              // halfwords of program
localparam int          N_VEC    = 23;              // instructions expected
localparam logic [31:0] ERR_ADDR = 32'h0000_0020;   // word answered with pslverr

// halfword image, index = byte address / 2, little endian
localparam logic [15:0] MEM_HW [N_HW] = '{
    16'h0093, 16'h0050, 16'h81b3, 16'h0020,   // 0x00  addi, add
    16'h0085, 16'h2283, 16'h0081, 16'h557d,   // 0x08  c.addi, lw straddles, c.li
    16'h85aa, 16'h4044, 16'hc404, 16'ha011,   // 0x10
    16'he481, 16'h800d, 16'h6285, 16'h9316,   // 0x18
    16'h0113, 16'h0101, 16'h0001, 16'h8082,   // 0x20  word 0x20 gets pslverr
    16'h0000, 16'h0004, 16'h4012, 16'h8002,   // 0x28  reserved encodings
    16'h1086, 16'h2623, 16'h0051, 16'h008a    // 0x30  sw straddles 0x30/0x34
};

// columns: pc, expanded instruction, compressed, illegal, bus_err
localparam fetch_instr_t EXP_TAB [N_VEC] = '{
    '{32'h0000_0000, 32'h0050_0093, 1'b0, 1'b0, 1'b0},   // addi x1,x0,5
    '{32'h0000_0004, 32'h0020_81b3, 1'b0, 1'b0, 1'b0},   // add x3,x1,x2
    '{32'h0000_0008, 32'h0010_8093, 1'b1, 1'b0, 1'b0},   // c.addi x1,1
    '{32'h0000_000a, 32'h0081_2283, 1'b0, 1'b0, 1'b0},   // lw x5,8(x2) across words
    '{32'h0000_000e, 32'hfff0_0513, 1'b1, 1'b0, 1'b0},   // c.li x10,-1
    '{32'h0000_0010, 32'h00a0_05b3, 1'b1, 1'b0, 1'b0},   // c.mv x11,x10
    '{32'h0000_0012, 32'h0044_2483, 1'b1, 1'b0, 1'b0},   // c.lw x9,4(x8)
    '{32'h0000_0014, 32'h0094_2423, 1'b1, 1'b0, 1'b0},   // c.sw x9,8(x8)
    '{32'h0000_0016, 32'h0040_006f, 1'b1, 1'b0, 1'b0},   // c.j +4
    '{32'h0000_0018, 32'h0004_9463, 1'b1, 1'b0, 1'b0},   // c.bnez x9,+8
    '{32'h0000_001a, 32'h0034_5413, 1'b1, 1'b0, 1'b0},   // c.srli x8,3
    '{32'h0000_001c, 32'h0000_12b7, 1'b1, 1'b0, 1'b0},   // c.lui x5,1
    '{32'h0000_001e, 32'h0053_0333, 1'b1, 1'b0, 1'b0},   // c.add x6,x5
    '{32'h0000_0020, 32'h0101_0113, 1'b0, 1'b0, 1'b1},   // addi x2,x2,16 from bad word
    '{32'h0000_0024, 32'h0000_0013, 1'b1, 1'b0, 1'b0},   // c.nop
    '{32'h0000_0026, 32'h0000_8067, 1'b1, 1'b0, 1'b0},   // c.jr x1
    '{32'h0000_0028, 32'h0000_0000, 1'b1, 1'b1, 1'b0},   // all zero
    '{32'h0000_002a, 32'h0000_0000, 1'b1, 1'b1, 1'b0},   // c.addi4spn imm 0
    '{32'h0000_002c, 32'h0000_0000, 1'b1, 1'b1, 1'b0},   // c.lwsp x0
    '{32'h0000_002e, 32'h0000_0000, 1'b1, 1'b1, 1'b0},   // c.jr x0
    '{32'h0000_0030, 32'h0000_0000, 1'b1, 1'b1, 1'b0},   // c.slli shamt[5]
    '{32'h0000_0032, 32'h0051_2623, 1'b0, 1'b0, 1'b0},   // sw x5,12(x2) across words
    '{32'h0000_0036, 32'h0020_9093, 1'b1, 1'b0, 1'b0}    // c.slli x1,2
};

string test_name [N_VEC] = '{
    "addi", "add", "c.addi", "lw_split", "c.li", "c.mv", "c.lw", "c.sw",
    "c.j", "c.bnez", "c.srli", "c.lui", "c.add", "addi_err", "c.nop", "c.jr",
    "ill_zero", "ill_4spn", "ill_lwsp", "ill_jr", "ill_slli", "sw_split", "c.slli"
};

`endif

// ==== tb_fetch.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_fetch
    import rvc_pkg::*;
();

    `include "tb_vectors.svh"

    localparam int TIMEOUT_CYCLES = N_VEC * 4 * (2 + 3) * 20;   // words x worst transfer x margin

    logic            clk, rst_n;
    logic            psel, penable, pready, pslverr;
    logic [XLEN-1:0] paddr, prdata;
    logic            inst_valid, inst_ready;
    fetch_instr_t    inst;
    int unsigned     wait_left;         // wait states still to insert
    int              idx, pass_cnt, fail_cnt;

    fetch_top fetch_top_i (
        .clk_i (clk), .rst_i (rst_n),
        .psel_o (psel), .penable_o (penable), .paddr_o (paddr),
        .prdata_i (prdata), .pready_i (pready), .pslverr_i (pslverr),
        .inst_valid_o (inst_valid), .inst_o (inst), .inst_ready_i (inst_ready)
    );

    always #5 clk = ~clk;   // 10 ns period

    // ------------------------------------------------------------------
    // apb memory model, answers on falling edges
    // ------------------------------------------------------------------
    function automatic logic [31:0] read_word(input logic [31:0] addr);
        if (addr < 2 * N_HW)
            return {MEM_HW[addr[31:1] + 1], MEM_HW[addr[31:1]]};
        return addr ^ 32'h5a5a_c3c3;    // past the program
    endfunction

    always @(negedge clk) begin
        pready  = 1'b0;
        pslverr = 1'b0;
        if (psel && !penable) begin
            wait_left = $urandom % 4;           // 0..3 wait states
        end else if (psel && penable) begin
            if (wait_left == 0) begin
                pready  = 1'b1;
                prdata  = read_word(paddr);
                pslverr = (paddr == ERR_ADDR);
            end else begin
                wait_left = wait_left - 1;
            end
        end
    end

    // ------------------------------------------------------------------
    // compare one handshake against the table
    // ------------------------------------------------------------------
    task automatic check_entry(input int i);
        fetch_instr_t exp;
        bit           ok;
        exp = EXP_TAB[i];
        ok  = 1'b1;
        if (inst.pc != exp.pc)
            ok = 1'b0;
        if (!exp.illegal && inst.instr != exp.instr)   // expansion of reserved codes is don't care
            ok = 1'b0;
        if (inst.compressed != exp.compressed)
            ok = 1'b0;
        if (inst.illegal != exp.illegal)
            ok = 1'b0;
        if (inst.bus_err != exp.bus_err)
            ok = 1'b0;
        if (ok) begin
            pass_cnt++;
            $display("PASS %-9s pc=%h instr=%h", test_name[i], inst.pc, inst.instr);
        end else begin
            fail_cnt++;
            $display("FAIL %-9s exp pc=%h instr=%h cie=%b%b%b got pc=%h instr=%h cie=%b%b%b",
                     test_name[i], exp.pc, exp.instr, exp.compressed, exp.illegal, exp.bus_err,
                     inst.pc, inst.instr, inst.compressed, inst.illegal, inst.bus_err);
        end
    endtask

    // ------------------------------------------------------------------
    // stimulus loop
    // ------------------------------------------------------------------
    initial begin
        void'($urandom(32'h8911d6e1));
        clk        = 1'b0;
        rst_n      = 1'b0;
        prdata     = '0;
        pready     = 1'b0;
        pslverr    = 1'b0;
        inst_ready = 1'b0;
        wait_left  = 0;
        pass_cnt   = 0;
        fail_cnt   = 0;
        repeat (10) @(posedge clk);
        @(negedge clk) rst_n = 1'b1;
        idx = 0;
        while (idx < N_VEC) begin
            @(negedge clk);
            inst_ready = ($urandom % 4) != 0;   // ready about 3 cycles in 4
            if (inst_valid && inst_ready) begin  // taken on the next rising edge
                check_entry(idx);
                idx++;
            end
        end
        @(posedge clk);
        $display("tests: %0d passed, %0d failed of %0d", pass_cnt, fail_cnt, N_VEC);
        if (fail_cnt == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

    // watchdog
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout after %0d cycles, %0d of %0d instructions arrived",
                 TIMEOUT_CYCLES, idx, N_VEC);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire
